//--- verilog/ahb_mem_macros.svh
// ####################################################################
// bus and memory geometry shared by the whole memory subsystem
// the data width must be a multiple of 8 so byte lanes divide evenly
// the SRAM occupies SRAM_DEPTH words starting at SRAM_BASE
// every other address is unmapped and answered with ERROR
// ####################################################################
`ifndef AHB_MEM_MACROS_SVH
`define AHB_MEM_MACROS_SVH

// bus data width in bits
`define AHB_W_DATA 32

// bus address width in bits
`define AHB_W_ADDR 32

// number of SRAM words, 8 KiB at a 32-bit word
`define SRAM_DEPTH 2048

// first byte address of the SRAM region
`define SRAM_BASE 32'h0000_0000

`endif

//--- verilog/ahb_mem_pkg.sv
// ####################################################################
// types shared by the AHB-lite memory subsystem
// widths follow the geometry macros, change them there only
// htrans keeps the AHB encoding, bit 1 set means NONSEQ or SEQ
// ####################################################################
`include "ahb_mem_macros.svh"

package ahb_mem_pkg;

	typedef logic [`AHB_W_ADDR-1:0] haddr_t; // byte address on the bus

	typedef logic [`AHB_W_DATA-1:0] hdata_t; // one full data word

	// 00 IDLE, 01 BUSY, 10 NONSEQ, 11 SEQ
	typedef logic [1:0] htrans_t;

	// 000 byte, 001 halfword, 010 word, larger sizes are not used here
	typedef logic [2:0] hsize_t;

	typedef logic [`AHB_W_DATA/8-1:0] byte_mask_t; // one write enable per byte lane

	typedef logic [$clog2(`SRAM_DEPTH)-1:0] sram_addr_t; // word index into the SRAM

	// default slave response sequence, the two error states form the
	// mandatory two-cycle ERROR response
	typedef enum logic [1:0] {
		err_idle, // OKAY with no wait states
		err_first, // hresp high, hreadyout low
		err_second // hresp high, hreadyout high
	} err_state_t;

endpackage

//--- verilog/ahb_lite_if.sv
// ####################################################################
// AHB-lite signals between the splitter and one slave
// hready is the bus-wide ready, hreadyout is the slave's own ready
// no burst, protection or lock signals are carried
// ####################################################################
interface ahb_lite_if;

	logic hsel; // slave is selected in the address phase
	ahb_mem_pkg::haddr_t haddr; // byte address of the address phase
	logic hwrite; // high for a write transfer
	ahb_mem_pkg::htrans_t htrans; // transfer type
	ahb_mem_pkg::hsize_t hsize; // transfer size
	ahb_mem_pkg::hdata_t hwdata; // write data, valid in the data phase
	logic hready; // bus ready, a new address phase is taken when high

	logic hreadyout; // slave ends its data phase when high
	logic hresp; // high for an ERROR response
	ahb_mem_pkg::hdata_t hrdata; // read data, valid in the data phase

	// request side, driven by the address decoder
	modport splitter (
		output hsel,
		output haddr,
		output hwrite,
		output htrans,
		output hsize,
		output hwdata,
		output hready,
		input hreadyout,
		input hresp,
		input hrdata
	);

	// response side, driven by the slave
	modport slave (
		input hsel,
		input haddr,
		input hwrite,
		input htrans,
		input hsize,
		input hwdata,
		input hready,
		output hreadyout,
		output hresp,
		output hrdata
	);

endinterface

//--- verilog/sram_sync.sv
// ####################################################################
// single-port synchronous memory with per-byte write enables
// read data is registered and appears one cycle after the address
// a read and write to the same word on one edge returns the old word
// contents are undefined after power-up, there is no reset
// ####################################################################
`include "ahb_mem_macros.svh"

module sram_sync (
	input logic clk,
	input ahb_mem_pkg::byte_mask_t wen, // one enable per byte lane
	input ahb_mem_pkg::sram_addr_t addr, // word index for read and write
	input ahb_mem_pkg::hdata_t wdata,
	output ahb_mem_pkg::hdata_t rdata
);

	ahb_mem_pkg::hdata_t mem [`SRAM_DEPTH]; // storage array, one entry per word

	// each lane is written only when its enable bit is set
	always_ff @(posedge clk) begin
		for (int i = 0; i < $bits(wen); i++) begin
			if (wen[i]) begin
				mem[addr][i*8 +: 8] <= wdata[i*8 +: 8]; // lane i covers bits 8i to 8i+7
			end
		end
	end

	// the whole word is always read, lane selection is up to the master
	always_ff @(posedge clk) begin
		rdata <= mem[addr]; // sampled before this edge's write lands
	end

endmodule

//--- verilog/ahb_sync_sram.sv
// ####################################################################
// AHB-lite slave in front of a synchronous SRAM
// reads take no wait states, writes take exactly one
// the write commits on the edge that ends its wait state
// bursts are handled as single transfers, hresp is always OKAY
// ####################################################################
module ahb_sync_sram (
	input logic clk,
	input logic rst_n,
	ahb_lite_if.slave bus
);

	// number of address bits that select a byte within a word
	localparam int unsigned lane_bits = $clog2($bits(ahb_mem_pkg::byte_mask_t));

	ahb_mem_pkg::byte_mask_t size_mask; // lanes covered by hsize, starting at lane 0
	ahb_mem_pkg::byte_mask_t wr_mask; // lanes of the current address phase
	ahb_mem_pkg::byte_mask_t wen; // registered lane enables for the SRAM
	ahb_mem_pkg::sram_addr_t bus_word; // word index of the live address phase
	ahb_mem_pkg::sram_addr_t addr_saved; // word index of the write in its wait state
	ahb_mem_pkg::sram_addr_t sram_addr; // address actually applied to the SRAM
	logic wr_accept; // a write address phase is taken on this edge
	logic wr_pending; // write data phase is in its wait cycle

	// only NONSEQ and SEQ carry a transfer, htrans bit 1 marks both
	assign wr_accept = bus.hsel && bus.hready && bus.htrans[1] && bus.hwrite;

	// a size of n covers 2**n lanes, anything wider than the bus is the full word
	always_comb begin
		size_mask = '0;
		for (int i = 0; i < $bits(size_mask); i++) begin
			if (i < (1 << bus.hsize)) begin
				size_mask[i] = 1'b1;
			end
		end
	end

	assign wr_mask = size_mask << bus.haddr[lane_bits-1:0]; // move lanes to the byte offset

	assign bus_word = bus.haddr[lane_bits +: $bits(ahb_mem_pkg::sram_addr_t)];

	// during the wait cycle the next address phase is already on the bus,
	// so the SRAM has to keep looking at the write's own word
	assign sram_addr = wr_pending ? addr_saved : bus_word;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_pending <= 1'b0;
			wen <= '0;
		end else begin
			wr_pending <= wr_accept; // one wait state per write, never more
			wen <= wr_accept ? wr_mask : '0; // enables live for the wait cycle only
		end
	end

	always_ff @(posedge clk) begin
		if (wr_accept) begin
			addr_saved <= bus_word;
		end
	end

	assign bus.hreadyout = !wr_pending; // low only while the write waits
	assign bus.hresp = 1'b0; // every mapped access succeeds

	// hwdata is valid through the whole write data phase, so it feeds the
	// SRAM directly on the committing edge
	sram_sync sram_i (
		.clk (clk),
		.wen (wen),
		.addr (sram_addr),
		.wdata (bus.hwdata),
		.rdata (bus.hrdata)
	);

endmodule

//--- verilog/ahb_default_slave.sv
// ####################################################################
// AHB-lite default slave for every unmapped address
// active transfers get the two-cycle ERROR response
// IDLE and BUSY get OKAY with no wait states, read data is always zero
// ####################################################################
module ahb_default_slave (
	input logic clk,
	input logic rst_n,
	ahb_lite_if.slave bus
);

	ahb_mem_pkg::err_state_t state; // current response state
	ahb_mem_pkg::err_state_t state_nxt;
	logic accept; // an active transfer to this slave is taken on this edge

	assign accept = bus.hsel && bus.hready && bus.htrans[1];

	always_comb begin
		state_nxt = state;
		case (state)
			ahb_mem_pkg::err_idle: begin
				if (accept) begin
					state_nxt = ahb_mem_pkg::err_first;
				end
			end
			ahb_mem_pkg::err_first: begin
				state_nxt = ahb_mem_pkg::err_second; // hready is low here, nothing new arrives
			end
			ahb_mem_pkg::err_second: begin
				// back-to-back unmapped transfers restart the sequence at once
				state_nxt = accept ? ahb_mem_pkg::err_first : ahb_mem_pkg::err_idle;
			end
			default: begin
				state_nxt = ahb_mem_pkg::err_idle;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ahb_mem_pkg::err_idle;
		end else begin
			state <= state_nxt;
		end
	end

	assign bus.hresp = (state == ahb_mem_pkg::err_first) ||
		(state == ahb_mem_pkg::err_second); // ERROR held over both cycles
	assign bus.hreadyout = (state != ahb_mem_pkg::err_first); // one wait state for ERROR
	assign bus.hrdata = '0; // nothing to read from an unmapped address

endmodule

//--- verilog/ahb_splitter.sv
// ####################################################################
// address decoder and response multiplexer for two AHB-lite slaves
// the SRAM region is SRAM_DEPTH words from SRAM_BASE, all else is
// routed to the default slave
// the multiplexed hreadyout is also the bus-wide hready, which holds
// for a single master on a single slave port
// ####################################################################
`include "ahb_mem_macros.svh"

module ahb_splitter (
	input logic clk,
	input logic rst_n,
	input ahb_mem_pkg::haddr_t haddr,
	input logic hwrite,
	input ahb_mem_pkg::htrans_t htrans,
	input ahb_mem_pkg::hsize_t hsize,
	input ahb_mem_pkg::hdata_t hwdata,
	output ahb_mem_pkg::hdata_t hrdata,
	output logic hreadyout,
	output logic hresp,
	ahb_lite_if.splitter sram,
	ahb_lite_if.splitter dflt
);

	// size of the SRAM region in bytes
	localparam ahb_mem_pkg::haddr_t sram_size =
		ahb_mem_pkg::haddr_t'(`SRAM_DEPTH * (`AHB_W_DATA / 8));

	ahb_mem_pkg::haddr_t sram_offset; // byte offset from the SRAM base
	logic in_sram; // address phase falls inside the SRAM region
	logic owner_sram; // SRAM owns the current data phase, else the default slave

	// unsigned offset compare covers both region ends with one comparator
	assign sram_offset = haddr - `SRAM_BASE;
	assign in_sram = (sram_offset < sram_size);

	// both slaves see the same request, only hsel differs
	assign sram.hsel = in_sram;
	assign sram.haddr = haddr;
	assign sram.hwrite = hwrite;
	assign sram.htrans = htrans;
	assign sram.hsize = hsize;
	assign sram.hwdata = hwdata;
	assign sram.hready = hreadyout;

	assign dflt.hsel = !in_sram; // everything outside the SRAM is unmapped
	assign dflt.haddr = haddr;
	assign dflt.hwrite = hwrite;
	assign dflt.htrans = htrans;
	assign dflt.hsize = hsize;
	assign dflt.hwdata = hwdata;
	assign dflt.hready = hreadyout;

	// owner moves only when an active address phase is taken, so an IDLE
	// leaves the last owner in place and both slaves answer OKAY then
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			owner_sram <= 1'b0; // default slave in err_idle answers OKAY
		end else if (hreadyout && htrans[1]) begin
			owner_sram <= in_sram;
		end
	end

	// response of the data-phase owner goes straight back, no added latency
	assign hreadyout = owner_sram ? sram.hreadyout : dflt.hreadyout;
	assign hresp = owner_sram ? sram.hresp : dflt.hresp;
	assign hrdata = owner_sram ? sram.hrdata : dflt.hrdata;

endmodule

//--- verilog/ahb_mem_subsystem.sv
// ####################################################################
// AHB-lite memory subsystem with an SRAM and a default slave
// a single master drives the port, hreadyout doubles as its hready
// the master must hold the address phase while hreadyout is low
// bursts are plain single transfers, no protection or lock support
// ####################################################################
module ahb_mem_subsystem (
	input logic clk,
	input logic rst_n,
	input ahb_mem_pkg::haddr_t haddr,
	input logic hwrite,
	input ahb_mem_pkg::htrans_t htrans,
	input ahb_mem_pkg::hsize_t hsize,
	input ahb_mem_pkg::hdata_t hwdata,
	output ahb_mem_pkg::hdata_t hrdata,
	output logic hreadyout,
	output logic hresp
);

	ahb_lite_if sram_bus (); // splitter to SRAM slave
	ahb_lite_if dflt_bus (); // splitter to default slave

	// decodes the address phase and returns the data-phase owner's response
	ahb_splitter splitter_i (
		.clk (clk),
		.rst_n (rst_n),
		.haddr (haddr),
		.hwrite (hwrite),
		.htrans (htrans),
		.hsize (hsize),
		.hwdata (hwdata),
		.hrdata (hrdata),
		.hreadyout (hreadyout),
		.hresp (hresp),
		.sram (sram_bus.splitter),
		.dflt (dflt_bus.splitter)
	);

	// 8 KiB on-chip memory, one wait state on writes
	ahb_sync_sram sram_i (
		.clk (clk),
		.rst_n (rst_n),
		.bus (sram_bus.slave)
	);

	// ERROR for every unmapped active transfer
	ahb_default_slave dflt_i (
		.clk (clk),
		.rst_n (rst_n),
		.bus (dflt_bus.slave)
	);

endmodule

//--- test/tb_ahb_mem_subsystem.sv
// ####################################################################
// pipelined single-master AHB-lite testbench for the memory subsystem
// the transfer table is built first, a reference memory gives the
// expected read data, then the table is applied one transfer per phase
// only NONSEQ and IDLE are driven, sizes are byte, halfword and word
// words that were never written are never read back
// ####################################################################
`include "ahb_mem_macros.svh"

module tb_ahb_mem_subsystem;

	localparam int clk_period = 8;
	localparam int reset_cycles = 4;
	localparam int max_wait = 16; // longest legal data phase is two cycles
	localparam int lanes = `AHB_W_DATA / 8;

	logic clk;
	logic rst_n;
	ahb_mem_pkg::haddr_t haddr;
	logic hwrite;
	ahb_mem_pkg::htrans_t htrans;
	ahb_mem_pkg::hsize_t hsize;
	ahb_mem_pkg::hdata_t hwdata;
	ahb_mem_pkg::hdata_t hrdata;
	logic hreadyout;
	logic hresp;

	// transfer table, one entry per index across all queues
	string t_name [$];
	logic t_write [$];
	ahb_mem_pkg::htrans_t t_trans [$];
	ahb_mem_pkg::haddr_t t_addr [$];
	ahb_mem_pkg::hsize_t t_size [$];
	ahb_mem_pkg::hdata_t t_wdata [$];
	ahb_mem_pkg::hdata_t t_exp [$]; // expected read data
	logic t_err [$]; // expected ERROR response

	ahb_mem_pkg::hdata_t ref_mem [`SRAM_DEPTH]; // reference copy of the SRAM
	ahb_mem_pkg::haddr_t rand_addr [$]; // addresses of the random writes
	integer seed;
	int checks;
	int errors;
	logic hung; // set once a wait ran out of time

	ahb_mem_subsystem dut_i (
		.clk (clk),
		.rst_n (rst_n),
		.haddr (haddr),
		.hwrite (hwrite),
		.htrans (htrans),
		.hsize (hsize),
		.hwdata (hwdata),
		.hrdata (hrdata),
		.hreadyout (hreadyout),
		.hresp (hresp)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(clk_period / 2) clk = ~clk;
		end
	end

	// true when the byte address lies in the SRAM window
	function automatic logic in_region(input ahb_mem_pkg::haddr_t addr);
		return (addr >= `SRAM_BASE) && (addr < `SRAM_BASE + `SRAM_DEPTH * lanes);
	endfunction

	// lanes from the low address bits up to 2**size bytes take the new data
	function automatic ahb_mem_pkg::hdata_t merge_lanes(input ahb_mem_pkg::hdata_t old,
		input ahb_mem_pkg::hdata_t wdata, input ahb_mem_pkg::haddr_t addr,
		input ahb_mem_pkg::hsize_t size);
		ahb_mem_pkg::hdata_t result;
		int first;
		int count;
		result = old;
		first = addr % lanes; // byte offset inside the word
		count = 1 << size;
		for (int b = 0; b < lanes; b++) begin
			if (b >= first && b < first + count) begin
				result[b*8 +: 8] = wdata[b*8 +: 8];
			end
		end
		return result;
	endfunction

	// appends one transfer and updates the reference memory in bus order
	task automatic add_transfer(input string name, input logic write,
		input ahb_mem_pkg::htrans_t trans, input ahb_mem_pkg::haddr_t addr,
		input ahb_mem_pkg::hsize_t size, input ahb_mem_pkg::hdata_t wdata);
		logic err;
		int word;
		ahb_mem_pkg::hdata_t exp;
		err = trans[1] && !in_region(addr); // unmapped active transfers fail
		word = (addr - `SRAM_BASE) / lanes;
		exp = '0;
		if (trans[1] && !err) begin
			if (write) begin
				ref_mem[word] = merge_lanes(ref_mem[word], wdata, addr, size);
			end else begin
				exp = ref_mem[word]; // reads always return the whole word
			end
		end
		t_name.push_back(name);
		t_write.push_back(write);
		t_trans.push_back(trans);
		t_addr.push_back(addr);
		t_size.push_back(size);
		t_wdata.push_back(wdata);
		t_exp.push_back(exp);
		t_err.push_back(err);
	endtask

	task automatic check_data(input string name, input ahb_mem_pkg::hdata_t exp,
		input ahb_mem_pkg::hdata_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("ERR %s hrdata: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_resp(input string name, input string what, input logic exp,
		input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("ERR %s %s: expected %b, actual %b", name, what, exp, act);
		end
	endtask

	// puts the address phase of entry idx on the bus, IDLE past the table end
	task automatic drive_addr(input int idx);
		if (idx < t_name.size()) begin
			haddr = t_addr[idx];
			hwrite = t_write[idx];
			htrans = t_trans[idx];
			hsize = t_size[idx];
		end else begin
			htrans = 2'b00;
			hwrite = 1'b0;
		end
	endtask

	// follows the data phase of entry idx until hreadyout, idx below 0 only waits
	task automatic complete_phase(input int idx);
		int waits;
		logic exp_wait;
		logic exp_err;
		string name;
		waits = 0;
		name = (idx >= 0) ? t_name[idx] : "start";
		exp_err = (idx >= 0) && t_err[idx];
		exp_wait = (idx >= 0) && t_trans[idx][1] && (t_err[idx] || t_write[idx]);
		@(negedge clk); // outputs are settled mid-cycle
		if (idx >= 0) begin
			check_resp(name, "hreadyout cycle 1", !exp_wait, hreadyout);
			check_resp(name, "hresp cycle 1", exp_err, hresp);
			if (exp_wait) begin
				@(negedge clk); // writes and errors end in their second cycle
				check_resp(name, "hreadyout cycle 2", 1'b1, hreadyout);
				check_resp(name, "hresp cycle 2", exp_err, hresp);
			end
		end
		while (!hreadyout && !hung) begin
			waits++;
			if (waits > max_wait) begin
				errors++;
				hung = 1'b1;
				$display("timeout: hreadyout stayed low for %0d cycles in %s", max_wait, name);
			end else begin
				@(negedge clk);
			end
		end
		if (idx >= 0 && !hung && t_trans[idx][1] && !t_write[idx] && !t_err[idx]) begin
			check_data(name, t_exp[idx], hrdata);
		end
	endtask

	initial begin
		ahb_mem_pkg::haddr_t a;
		seed = 33761;
		checks = 0;
		errors = 0;
		hung = 1'b0;
		rst_n = 1'b0;
		haddr = '0;
		hwrite = 1'b0;
		htrans = 2'b00;
		hsize = 3'd2;
		hwdata = '0;

		// word write and read back with an IDLE in between
		add_transfer("word_wr", 1'b1, 2'b10, 32'h0000_0100, 3'd2, 32'h1234_5678);
		add_transfer("idle_1", 1'b0, 2'b00, 32'h0000_0100, 3'd2, '0);
		add_transfer("word_rd", 1'b0, 2'b10, 32'h0000_0100, 3'd2, '0);
		// sub-word lanes merged into one word
		add_transfer("merge_base", 1'b1, 2'b10, 32'h0000_0200, 3'd2, 32'h1122_3344);
		add_transfer("byte_lane1", 1'b1, 2'b10, 32'h0000_0201, 3'd0, 32'hA5A5_A5A5);
		add_transfer("half_upper", 1'b1, 2'b10, 32'h0000_0202, 3'd1, 32'hBEEF_0000);
		add_transfer("merge_mid_rd", 1'b0, 2'b10, 32'h0000_0200, 3'd2, '0);
		add_transfer("idle_2", 1'b0, 2'b00, 32'h0000_0000, 3'd2, '0);
		add_transfer("byte_lane0", 1'b1, 2'b10, 32'h0000_0200, 3'd0, 32'h0000_00C3);
		add_transfer("merge_rd", 1'b0, 2'b10, 32'h0000_0200, 3'd2, '0);
		add_transfer("half_base", 1'b1, 2'b10, 32'h0000_0204, 3'd2, 32'hDEAD_BEEF);
		add_transfer("half_lower", 1'b1, 2'b10, 32'h0000_0204, 3'd1, 32'h5555_7777);
		add_transfer("half_rd", 1'b0, 2'b10, 32'h0000_0204, 3'd2, '0);
		// read right behind a write to the same word
		add_transfer("b2b_wr", 1'b1, 2'b10, 32'h0000_0300, 3'd2, 32'h0F0F_F0F0);
		add_transfer("b2b_rd", 1'b0, 2'b10, 32'h0000_0300, 3'd2, '0);
		add_transfer("b2b_byte_wr", 1'b1, 2'b10, 32'h0000_0303, 3'd0, 32'h9900_0000);
		add_transfer("b2b_byte_rd", 1'b0, 2'b10, 32'h0000_0300, 3'd2, '0);
		// unmapped accesses around the top of the SRAM
		add_transfer("top_wr", 1'b1, 2'b10, 32'h0000_1FFC, 3'd2, 32'hCAFE_F00D);
		add_transfer("bottom_wr", 1'b1, 2'b10, 32'h0000_0000, 3'd2, 32'h0BAD_C0DE);
		add_transfer("err_rd", 1'b0, 2'b10, 32'h0000_2000, 3'd2, '0);
		add_transfer("err_wr", 1'b1, 2'b10, 32'hFFFF_FFF0, 3'd2, 32'h7777_7777);
		add_transfer("idle_3", 1'b0, 2'b00, 32'h0000_2000, 3'd2, '0);
		add_transfer("err_wr_alias", 1'b1, 2'b10, 32'h0000_2000, 3'd2, 32'h6666_6666);
		add_transfer("top_rd", 1'b0, 2'b10, 32'h0000_1FFC, 3'd2, '0);
		add_transfer("bottom_rd", 1'b0, 2'b10, 32'h0000_0000, 3'd2, '0);
		add_transfer("idle_4", 1'b0, 2'b00, 32'h0000_0000, 3'd2, '0);

		// random word writes over the region, then read back in order
		for (int k = 0; k < 50; k++) begin
			a = `SRAM_BASE + ($random(seed) & (`SRAM_DEPTH - 1)) * lanes;
			rand_addr.push_back(a);
			add_transfer($sformatf("rand_wr_%0d", k), 1'b1, 2'b10, a, 3'd2, $random(seed));
		end
		foreach (rand_addr[k]) begin
			add_transfer($sformatf("rand_rd_%0d", k), 1'b0, 2'b10, rand_addr[k], 3'd2, '0);
		end

		repeat (reset_cycles) @(posedge clk);
		#1 rst_n = 1'b1;

		// entry i enters its address phase while entry i-1 is in its data phase
		for (int i = 0; i <= t_name.size() && !hung; i++) begin
			drive_addr(i);
			if (i > 0) begin
				hwdata = t_wdata[i-1]; // held through the whole data phase
			end
			complete_phase(i - 1);
			@(posedge clk);
			#1;
		end

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

//--- ahb_mem_subsystem.f
+incdir+verilog
verilog/ahb_mem_pkg.sv
verilog/ahb_lite_if.sv
verilog/sram_sync.sv
verilog/ahb_sync_sram.sv
verilog/ahb_default_slave.sv
verilog/ahb_splitter.sv
verilog/ahb_mem_subsystem.sv
test/tb_ahb_mem_subsystem.sv
